/* common/pad_pkg.sv */
//*********************************************************************
// Layout of a plain 12-bit latch-and-clock gamepad, two pads per port
// Button positions follow shift order, bit 0 is the first bit out
// Pads with more than 12 bits are not supported
//*********************************************************************

`default_nettype none

package pad_pkg;

    // Bits shifted out of each pad in one scan
    localparam int unsigned PAD_BITS = 12;

    // Number of pads sharing pad_latch and pad_clk
    localparam int unsigned PAD_COUNT = 2;

    // Button positions in the pad word
    // The first four come out while the d-pad is still waiting
    localparam int unsigned BTN_B      = 0;
    localparam int unsigned BTN_Y      = 1;
    localparam int unsigned BTN_SELECT = 2;
    localparam int unsigned BTN_START  = 3;

    // Directional pad
    localparam int unsigned BTN_UP     = 4;
    localparam int unsigned BTN_DOWN   = 5;
    localparam int unsigned BTN_LEFT   = 6;
    localparam int unsigned BTN_RIGHT  = 7;

    // Face buttons and shoulders close the word
    localparam int unsigned BTN_A      = 8;
    localparam int unsigned BTN_X      = 9;
    localparam int unsigned BTN_L      = 10;
    localparam int unsigned BTN_R      = 11;

endpackage

`default_nettype wire

/* common/pad_regs_pkg.sv */
//*********************************************************************
// APB register map of the gamepad block, byte offsets on an 8-bit bus
// Only the offsets listed here decode, all others give pslverr
//*********************************************************************

`default_nettype none

package pad_regs_pkg;

    localparam int unsigned APB_ADDR_W = 8;
    localparam int unsigned APB_DATA_W = 32;

    // Register offsets
    localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_PAD0     = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_PAD1     = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_PRESSED0 = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_PRESSED1 = 8'h14;

    // CTRL bits, start is write-one and reads back as 0
    localparam int unsigned CTRL_ENABLE_BIT = 0;
    localparam int unsigned CTRL_START_BIT  = 1;

    // STATUS bits, new_data clears when STATUS is read
    localparam int unsigned STAT_BUSY_BIT = 0;
    localparam int unsigned STAT_NEW_BIT  = 1;

endpackage

`default_nettype wire

/* pad_reader/pad_scanner.sv */
//*********************************************************************
// Latch-and-clock scan of two serial gamepads, data lines active low
// CLK_DIV is the half period of pad_clk in clk_2x cycles, at least 2
// A scan takes 26*CLK_DIV cycles, SCAN_GAP idles between scans
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

module pad_scanner #(
    parameter int unsigned CLK_DIV  = 6,
    parameter int unsigned SCAN_GAP = 4096
) (
    input  wire                               clk_2x,
    input  wire                               reset,
    input  wire                               scan_enable,
    input  wire                               scan_start,
    output logic                              busy,
    output logic                              scan_done,
    output logic [pad_pkg::PAD_BITS-1:0]      pad0_state,
    output logic [pad_pkg::PAD_BITS-1:0]      pad1_state,
    output logic                              pad_latch,
    output logic                              pad_clk,
    input  wire  [pad_pkg::PAD_COUNT-1:0]     pad_data
);
    import pad_pkg::*;

    localparam int unsigned DIV_W = $clog2(2 * CLK_DIV);
    localparam int unsigned GAP_W = (SCAN_GAP > 0) ? $clog2(SCAN_GAP + 1) : 1;
    localparam int unsigned BIT_W = $clog2(PAD_BITS);

    localparam logic [DIV_W-1:0] LATCH_LAST = DIV_W'(2 * CLK_DIV - 1);
    localparam logic [DIV_W-1:0] HALF_LAST  = DIV_W'(CLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST   = BIT_W'(PAD_BITS - 1);
    localparam logic [GAP_W-1:0] GAP_LOAD   = GAP_W'(SCAN_GAP);

    // Phase bits are {busy, latch, clock low}, so the pad lines come
    // straight from flops and cannot glitch on a phase change
    localparam logic [2:0] PH_IDLE  = 3'b000;
    localparam logic [2:0] PH_LATCH = 3'b110;
    localparam logic [2:0] PH_LOW   = 3'b101;
    localparam logic [2:0] PH_HIGH  = 3'b100;

    logic [2:0]          phase;
    logic [DIV_W-1:0]    div_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic [GAP_W-1:0]    gap_cnt;
    logic [PAD_BITS-1:0] shift0;
    logic [PAD_BITS-1:0] shift1;
    logic                start_cond;
    logic                sample_en;
    logic                scan_last;

    assign busy      = phase[2];
    assign pad_latch = phase[1];
    assign pad_clk   = ~phase[0];

    // A request is taken only while idle, enable waits for the gap
    assign start_cond = (phase == PH_IDLE) &&
                        (scan_start || (scan_enable && gap_cnt == '0));

    // Last cycle of a low half, the pad has settled on the current bit
    assign sample_en = (phase == PH_LOW) && (div_cnt == HALF_LAST);

    // Last cycle of the final high half
    assign scan_last = (phase == PH_HIGH) && (div_cnt == HALF_LAST) &&
                       (bit_cnt == BIT_LAST);

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            phase     <= PH_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            gap_cnt   <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            // The gap runs down on its own and is reloaded when a scan ends
            if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
            case (phase)
                PH_IDLE: begin
                    if (start_cond) begin
                        phase   <= PH_LATCH;
                        div_cnt <= '0;
                    end
                end
                PH_LATCH: begin
                    if (div_cnt == LATCH_LAST) begin
                        phase   <= PH_LOW;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                PH_LOW: begin
                    if (div_cnt == HALF_LAST) begin
                        phase   <= PH_HIGH;
                        div_cnt <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    // Clock high half, the rising edge moves the pads on
                    if (div_cnt == HALF_LAST) begin
                        div_cnt <= '0;
                        if (scan_last) begin
                            phase     <= PH_IDLE;
                            scan_done <= 1'b1;
                            gap_cnt   <= GAP_LOAD;
                        end else begin
                            phase   <= PH_LOW;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Bits enter at the top and move down, so bit 0 ends at position 0
    // Pad lines are active low and are inverted on the way in
    always_ff @(posedge clk_2x) begin
        if (sample_en) begin
            shift0 <= {~pad_data[0], shift0[PAD_BITS-1:1]};
            shift1 <= {~pad_data[1], shift1[PAD_BITS-1:1]};
        end
        // Published on the same edge that raises scan_done
        if (scan_last) begin
            pad0_state <= shift0;
            pad1_state <= shift1;
        end
    end

endmodule

`default_nettype wire

/* pad_reader/pad_regs.sv */
//*********************************************************************
// APB register block of the gamepad reader, no wait states
// PRESSED and STATUS new_data clear on read, a scan in the same cycle
// keeps its new bits. Unmapped offsets give pslverr and read 0
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

module pad_regs (
    input  wire                                  clk_2x,
    input  wire                                  reset,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [pad_regs_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire  [pad_regs_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [pad_regs_pkg::APB_DATA_W-1:0]  prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 scan_enable,
    output logic                                 scan_start,
    input  wire                                  busy,
    input  wire                                  scan_done,
    input  wire  [pad_pkg::PAD_BITS-1:0]         pad0_state,
    input  wire  [pad_pkg::PAD_BITS-1:0]         pad1_state
);
    import pad_pkg::*;
    import pad_regs_pkg::*;

    logic                access;
    logic                addr_hit;
    logic                wr_en;
    logic                rd_en;
    logic                new_data;
    logic [PAD_BITS-1:0] pad0_reg;
    logic [PAD_BITS-1:0] pad1_reg;
    logic [PAD_BITS-1:0] pressed0;
    logic [PAD_BITS-1:0] pressed1;
    logic [PAD_BITS-1:0] edges0;
    logic [PAD_BITS-1:0] edges1;

    // The access phase always completes in one cycle
    assign pready = 1'b1;

    assign access = psel & penable;
    assign wr_en  = access & pwrite & addr_hit;
    assign rd_en  = access & ~pwrite & addr_hit;

    assign pslverr = access & ~addr_hit;

    // Buttons that are down now and were up in the previous scan
    assign edges0 = pad0_state & ~pad0_reg;
    assign edges1 = pad1_state & ~pad1_reg;

    // Read mux doubles as the address decoder
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            REG_CTRL: begin
                prdata[CTRL_ENABLE_BIT] = scan_enable;
            end
            REG_STATUS: begin
                prdata[STAT_BUSY_BIT] = busy;
                prdata[STAT_NEW_BIT]  = new_data;
            end
            REG_PAD0:     prdata[PAD_BITS-1:0] = pad0_reg;
            REG_PAD1:     prdata[PAD_BITS-1:0] = pad1_reg;
            REG_PRESSED0: prdata[PAD_BITS-1:0] = pressed0;
            REG_PRESSED1: prdata[PAD_BITS-1:0] = pressed1;
            default:      addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            scan_enable <= 1'b0;
            scan_start  <= 1'b0;
            new_data    <= 1'b0;
            pad0_reg    <= '0;
            pad1_reg    <= '0;
            pressed0    <= '0;
            pressed1    <= '0;
        end else begin
            // Start is a single pulse and never stored
            scan_start <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
            if (wr_en && paddr == REG_CTRL) begin
                scan_enable <= pwdata[CTRL_ENABLE_BIT];
            end

            // Set wins over the clearing read
            if (scan_done) begin
                new_data <= 1'b1;
            end else if (rd_en && paddr == REG_STATUS) begin
                new_data <= 1'b0;
            end

            if (scan_done) begin
                pad0_reg <= pad0_state;
                pad1_reg <= pad1_state;
            end

            // Clear first, then OR in any edges from a scan ending now
            pressed0 <= ((rd_en && paddr == REG_PRESSED0) ? '0 : pressed0) |
                        (scan_done ? edges0 : '0);
            pressed1 <= ((rd_en && paddr == REG_PRESSED1) ? '0 : pressed1) |
                        (scan_done ? edges1 : '0);
        end
    end

endmodule

`default_nettype wire

/* design/pad_top.sv */
//*********************************************************************
// Gamepad reader, APB registers beside a two-pad scan sequencer
// CLK_DIV must be at least 2, SCAN_GAP may be 0
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

module pad_top #(
    parameter int unsigned CLK_DIV  = 6,
    parameter int unsigned SCAN_GAP = 4096
) (
    input  wire                                  clk_2x,
    input  wire                                  reset,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [pad_regs_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire  [pad_regs_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [pad_regs_pkg::APB_DATA_W-1:0]  prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 pad_latch,
    output logic                                 pad_clk,
    input  wire  [pad_pkg::PAD_COUNT-1:0]        pad_data
);
    import pad_pkg::*;

    // Control from the registers, results back from the scanner
    logic                scan_enable;
    logic                scan_start;
    logic                busy;
    logic                scan_done;
    logic [PAD_BITS-1:0] pad0_state;
    logic [PAD_BITS-1:0] pad1_state;

    pad_regs pad_regs_i (
        .clk_2x      (clk_2x),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .scan_enable (scan_enable),
        .scan_start  (scan_start),
        .busy        (busy),
        .scan_done   (scan_done),
        .pad0_state  (pad0_state),
        .pad1_state  (pad1_state)
    );

    pad_scanner #(
        .CLK_DIV  (CLK_DIV),
        .SCAN_GAP (SCAN_GAP)
    ) pad_scanner_i (
        .clk_2x      (clk_2x),
        .reset       (reset),
        .scan_enable (scan_enable),
        .scan_start  (scan_start),
        .busy        (busy),
        .scan_done   (scan_done),
        .pad0_state  (pad0_state),
        .pad1_state  (pad1_state),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk),
        .pad_data    (pad_data)
    );

endmodule

`default_nettype wire

/* sim/pad_top_chk.sv */
//*********************************************************************
// Protocol assertions on the pad lines and the APB port of pad_top
// All properties are off while reset is high
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

module pad_top_chk (
    input wire clk_2x,
    input wire reset,
    input wire pad_latch,
    input wire pad_clk,
    input wire scan_done,
    input wire psel,
    input wire penable,
    input wire pready,
    input wire pslverr
);

    // A pad must never see a clock edge during the latch pulse
    assert property (@(posedge clk_2x) disable iff (reset) pad_latch |-> pad_clk)
        else $error("pad_latch high while pad_clk is low");

    assert property (@(posedge clk_2x) disable iff (reset) scan_done |=> !scan_done)
        else $error("scan_done longer than one cycle");

    // No wait states on this port
    assert property (@(posedge clk_2x) disable iff (reset) pready)
        else $error("pready low");

    assert property (@(posedge clk_2x) disable iff (reset) pslverr |-> psel && penable)
        else $error("pslverr outside an access phase");

endmodule

bind pad_top pad_top_chk pad_top_chk_i (
    .clk_2x    (clk_2x),
    .reset     (reset),
    .pad_latch (pad_latch),
    .pad_clk   (pad_clk),
    .scan_done (scan_done),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr)
);

`default_nettype wire

/* sim/tb_pad_top.sv */
//*********************************************************************
// Testbench of the gamepad reader, CLK_DIV 3 and SCAN_GAP 10
// A mock pad pair shifts random words, a model tracks every register
// Reads are sampled on the falling edge inside the access phase
//*********************************************************************

`timescale 1ns/10ps
`default_nettype none

module tb_pad_top;
    import pad_pkg::*;
    import pad_regs_pkg::*;

    localparam int unsigned CLK_DIV  = 3;
    localparam int unsigned SCAN_GAP = 10;
    localparam int unsigned SCAN_LEN = 26 * CLK_DIV;
    // Rough count of scans over all tests, doubled for the limit
    localparam int unsigned NUM_SCANS = 40;
    localparam int unsigned TIMEOUT   = 2 * NUM_SCANS * (SCAN_LEN + SCAN_GAP + 40);

    logic                  clk_2x;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  pad_latch;
    logic                  pad_clk;
    logic [PAD_COUNT-1:0]  pad_data;

    // Mock pad state
    logic [PAD_BITS-1:0] btn0;
    logic [PAD_BITS-1:0] btn1;
    logic [PAD_BITS-1:0] cap0;
    logic [PAD_BITS-1:0] cap1;
    logic [PAD_BITS-1:0] sh0;
    logic [PAD_BITS-1:0] sh1;
    logic                clk_prev;
    int unsigned         rise_cnt;
    int unsigned         upd_cnt;
    int unsigned         scans_seen;

    // Reference model of the registers
    logic [PAD_BITS-1:0] exp_pad0;
    logic [PAD_BITS-1:0] exp_pad1;
    logic [PAD_BITS-1:0] exp_pr0;
    logic [PAD_BITS-1:0] exp_pr1;
    logic                exp_new;
    logic                exp_busy;
    logic                exp_enable;

    logic [31:0] rng;
    int unsigned cycles;

    pad_top #(
        .CLK_DIV  (CLK_DIV),
        .SCAN_GAP (SCAN_GAP)
    ) pad_top_i (
        .clk_2x    (clk_2x),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_data  (pad_data)
    );

    always #20 clk_2x = ~clk_2x;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_mapped(input logic [APB_ADDR_W-1:0] addr);
        return addr == REG_CTRL || addr == REG_STATUS || addr == REG_PAD0 ||
               addr == REG_PAD1 || addr == REG_PRESSED0 || addr == REG_PRESSED1;
    endfunction

    // What the register map should hold right now
    function automatic logic [31:0] model_value(input logic [APB_ADDR_W-1:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            REG_CTRL:     v[CTRL_ENABLE_BIT] = exp_enable;
            REG_STATUS: begin
                v[STAT_BUSY_BIT] = exp_busy;
                v[STAT_NEW_BIT]  = exp_new;
            end
            REG_PAD0:     v[PAD_BITS-1:0] = exp_pad0;
            REG_PAD1:     v[PAD_BITS-1:0] = exp_pad1;
            REG_PRESSED0: v[PAD_BITS-1:0] = exp_pr0;
            REG_PRESSED1: v[PAD_BITS-1:0] = exp_pr1;
            default:      v = '0;
        endcase
        return v;
    endfunction

    task automatic compare_val(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is 0x%h, expected 0x%h", $time, what,
                     actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk_2x);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_2x);
        penable <= 1'b1;
        @(negedge clk_2x);
        compare_val(32'(pslverr), 32'(!is_mapped(addr)), "pslverr on write");
        compare_val(32'(pready), 32'd1, "pready on write");
        @(posedge clk_2x);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // Reads one register, compares it with the model and applies clear on read
    task automatic read_check(input logic [APB_ADDR_W-1:0] addr, input string what);
        @(posedge clk_2x);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_2x);
        penable <= 1'b1;
        @(negedge clk_2x);
        compare_val(prdata, model_value(addr), what);
        compare_val(32'(pslverr), 32'(!is_mapped(addr)), "pslverr on read");
        compare_val(32'(pready), 32'd1, "pready on read");
        if (addr == REG_STATUS) begin
            exp_new = 1'b0;
        end
        if (addr == REG_PRESSED0) begin
            exp_pr0 = '0;
        end
        if (addr == REG_PRESSED1) begin
            exp_pr1 = '0;
        end
        @(posedge clk_2x);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic new_buttons();
        rng = xorshift(rng);
        @(posedge clk_2x);
        btn0 <= rng[11:0];
        btn1 <= rng[27:16];
    endtask

    // Returns once the model has taken the next completed scan
    task automatic wait_scan_end();
        int unsigned n;
        n = scans_seen;
        while (scans_seen == n) begin
            @(posedge clk_2x);
        end
    endtask

    // Mock pads, sampled on the rising edge like any other logic
    always @(posedge clk_2x) begin
        if (!reset) begin
            if (pad_latch) begin
                cap0     <= btn0;
                cap1     <= btn1;
                sh0      <= btn0;
                sh1      <= btn1;
                pad_data <= ~{btn1[0], btn0[0]};
                rise_cnt <= 0;
            end else if (pad_clk && !clk_prev) begin
                sh0      <= {1'b0, sh0[PAD_BITS-1:1]};
                sh1      <= {1'b0, sh1[PAD_BITS-1:1]};
                pad_data <= ~{sh1[1], sh0[1]};
                rise_cnt <= rise_cnt + 1;
                // The last rising edge, the scan ends one high half later
                if (rise_cnt == PAD_BITS - 1) begin
                    upd_cnt <= CLK_DIV;
                end
            end
            clk_prev <= pad_clk;
            // The registers change one cycle after scan_done
            if (upd_cnt != 0) begin
                upd_cnt <= upd_cnt - 1;
                if (upd_cnt == 1) begin
                    exp_pr0    = exp_pr0 | (cap0 & ~exp_pad0);
                    exp_pr1    = exp_pr1 | (cap1 & ~exp_pad1);
                    exp_pad0   = cap0;
                    exp_pad1   = cap1;
                    exp_new    = 1'b1;
                    scans_seen = scans_seen + 1;
                end
            end
        end
    end

    always @(posedge clk_2x) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk_2x     = 1'b0;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pad_data   = 2'b11;
        btn0       = '0;
        btn1       = '0;
        cap0       = '0;
        cap1       = '0;
        sh0        = '0;
        sh1        = '0;
        clk_prev   = 1'b1;
        rise_cnt   = 0;
        upd_cnt    = 0;
        scans_seen = 0;
        exp_pad0   = '0;
        exp_pad1   = '0;
        exp_pr0    = '0;
        exp_pr1    = '0;
        exp_new    = 1'b0;
        exp_busy   = 1'b0;
        exp_enable = 1'b0;
        rng        = 32'h4455_4f06;
        cycles     = 0;
        repeat (16) @(posedge clk_2x);
        reset <= 1'b0;

        // Registers and pad lines after reset
        read_check(REG_CTRL, "CTRL after reset");
        read_check(REG_STATUS, "STATUS after reset");
        read_check(REG_PAD0, "PAD0 after reset");
        read_check(REG_PAD1, "PAD1 after reset");
        read_check(REG_PRESSED0, "PRESSED0 after reset");
        read_check(REG_PRESSED1, "PRESSED1 after reset");
        @(negedge clk_2x);
        compare_val(32'(pad_latch), 32'd0, "pad_latch when idle");
        compare_val(32'(pad_clk), 32'd1, "pad_clk when idle");

        // One requested scan, busy while it runs and new_data after it
        new_buttons();
        write_reg(REG_CTRL, 32'h2);
        exp_busy = 1'b1;
        read_check(REG_STATUS, "STATUS during scan");
        read_check(REG_CTRL, "CTRL start bit");
        wait_scan_end();
        exp_busy = 1'b0;
        read_check(REG_STATUS, "STATUS after scan");
        read_check(REG_STATUS, "STATUS second read");
        read_check(REG_PAD0, "PAD0 after scan");
        read_check(REG_PAD1, "PAD1 after scan");

        // Pressed bits pile up over several scans and clear on read
        for (int i = 0; i < 8; i++) begin
            new_buttons();
            write_reg(REG_CTRL, 32'h2);
            wait_scan_end();
            if (i % 3 == 2) begin
                read_check(REG_PRESSED0, "PRESSED0");
                read_check(REG_PRESSED0, "PRESSED0 second read");
                read_check(REG_PRESSED1, "PRESSED1");
                read_check(REG_PRESSED1, "PRESSED1 second read");
            end
        end

        // Continuous scanning while the buttons move at random
        write_reg(REG_CTRL, 32'h1);
        exp_enable = 1'b1;
        for (int i = 0; i < 12; i++) begin
            new_buttons();
            rng = xorshift(rng);
            repeat (rng % 100) @(posedge clk_2x);
            read_check(REG_PAD0, "PAD0 in continuous mode");
            read_check(REG_PAD1, "PAD1 in continuous mode");
            read_check(REG_PRESSED0, "PRESSED0 in continuous mode");
        end
        write_reg(REG_CTRL, 32'h0);
        exp_enable = 1'b0;
        // Let a scan that already started run out
        repeat (SCAN_LEN + 4) @(posedge clk_2x);
        for (int i = 0; i < 2 * (SCAN_LEN + SCAN_GAP); i++) begin
            @(negedge clk_2x);
            compare_val(32'(pad_latch), 32'd0, "pad_latch after disable");
        end
        read_check(REG_PAD0, "PAD0 after disable");
        read_check(REG_PAD1, "PAD1 after disable");

        // Unmapped offsets
        read_check(8'h18, "unmapped 0x18");
        read_check(8'h40, "unmapped 0x40");
        read_check(8'hFF, "unmapped 0xFF");
        write_reg(8'h18, 32'hFFFF_FFFF);
        write_reg(8'h02, 32'h0000_0003);
        repeat (4) @(posedge clk_2x);
        read_check(REG_CTRL, "CTRL after unmapped writes");
        read_check(REG_STATUS, "STATUS after unmapped writes");
        read_check(REG_PAD0, "PAD0 after unmapped writes");
        read_check(REG_PAD1, "PAD1 after unmapped writes");
        read_check(REG_PRESSED0, "PRESSED0 after unmapped writes");
        read_check(REG_PRESSED1, "PRESSED1 after unmapped writes");

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
common/pad_pkg.sv
common/pad_regs_pkg.sv
pad_reader/pad_scanner.sv
pad_reader/pad_regs.sv
design/pad_top.sv
sim/pad_top_chk.sv
sim/tb_pad_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the gamepad reader testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_pad_top \
    -o tb_pad_top > build.log 2>&1 \
    && ./obj_dir/tb_pad_top > sim.log 2>&1 \
    || echo "Build or simulation stopped early, see build.log and sim.log"

grep -q "Finished with no errors" sim.log 2>/dev/null \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
